/* source/oflow_cfg_pkg.sv */
// optical-flow tracker configuration
// sizes, match threshold and the vector types of boxes,
// distances, counts and track ids
package oflow_cfg_pkg;

	// -----------------------------------------------
	// sizes and thresholds
	localparam int PE_NUM      = 4;  // boxes per set, parallel lanes
	localparam int MAX_BBOX    = 16; // largest frame
	localparam int SET_CREDITS = 2;  // sender credits after reset
	localparam int MATCH_DIST  = 8;  // largest accepted manhattan distance

	// -----------------------------------------------
	// vector types
	typedef logic [7:0]             coord_t;     // centroid coordinate
	typedef logic [15:0]            bbox_t;      // x upper byte, y lower byte
	typedef logic [PE_NUM*16-1:0]   bbox_set_t;  // PE_NUM boxes side by side
	typedef logic [8:0]             dist_t;      // |dx| + |dy|
	typedef logic [3:0]             bbox_idx_t;  // box index in frame
	typedef logic [4:0]             bbox_cnt_t;  // 0..16 boxes
	typedef logic [2:0]             set_cnt_t;   // sets in a frame
	typedef logic [7:0]             track_id_t;  // wraps
	typedef logic [7:0]             frame_num_t;

endpackage

/* source/oflow_ctrl_pkg.sv */
// optical-flow tracker control encodings
// states of the frame sequencer and of the pe array scan
package oflow_ctrl_pkg;

	typedef enum logic [2:0] {
		idle_st,              // waiting for start
		set_variables_st,     // count latched, sets computed
		scan_st,              // pe array running per set
		conflict_resolve_st,  // resolver walking boxes
		write_st              // current -> previous swap
	} core_state_t;

	typedef enum logic [1:0] {
		pe_wait_st,   // queue empty or scan not enabled
		pe_scan_st,   // one previous box per cycle
		pe_store_st   // results out to buffer
	} pe_state_t;

endpackage

/* source/oflow_core_fsm.sv */
// frame sequencer of the tracker core
// accepts a frame, counts its sets as the pe array finishes them,
// then starts conflict resolve and the memory swap, counts frames
`timescale 1ns/1ps

module oflow_core_fsm (
	input  logic                     clk,
	input  logic                     reset_N,
	input  logic                     start,
	input  oflow_cfg_pkg::bbox_cnt_t num_of_bbox_in_frame,
	input  logic                     done_set,
	input  logic                     done_cr,
	input  logic                     done_write,
	output logic                     ready_new_frame,
	output logic                     start_pe,
	output logic                     start_cr,
	output logic                     start_write_mem,
	output logic                     frame_done,
	output oflow_cfg_pkg::set_cnt_t  set_index,
	output oflow_cfg_pkg::bbox_cnt_t frame_bbox_cnt,
	output oflow_cfg_pkg::frame_num_t frame_num
);
	import oflow_cfg_pkg::*;
	import oflow_ctrl_pkg::*;

	core_state_t state;
	core_state_t next_state;
	set_cnt_t    num_sets;  // ceil(count / 4)
	logic        last_set;

	assign last_set = (set_index == num_sets - 3'd1);

	// --------------------------------------------------
	// state register
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			state <= idle_st;
		else
			state <= next_state;
	end

	// --------------------------------------------------
	// frame variables and counters
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			frame_bbox_cnt <= '0;
			num_sets       <= '0;
			set_index      <= '0;
			frame_num      <= '0;
		end else begin
			if (state == idle_st && start)
				frame_bbox_cnt <= num_of_bbox_in_frame; // held for the whole frame
			if (state == set_variables_st) begin
				num_sets  <= set_cnt_t'((frame_bbox_cnt + 5'd3) >> 2); // round up
				set_index <= '0;
			end else if (state == scan_st && done_set) begin
				set_index <= set_index + 3'd1; // next set base
			end
			if (state == write_st && done_write)
				frame_num <= frame_num + 8'd1;
		end
	end

	// --------------------------------------------------
	// next state and phase starts
	always_comb begin
		next_state      = state;
		ready_new_frame = 1'b0;
		start_pe        = 1'b0;
		start_cr        = 1'b0;
		start_write_mem = 1'b0;
		frame_done      = 1'b0;
		case (state)
			idle_st: begin
				ready_new_frame = 1'b1;
				if (start)
					next_state = set_variables_st;
			end
			set_variables_st: next_state = scan_st;
			scan_st: begin
				start_pe = 1'b1; // level, array pops only now
				if (done_set && last_set) begin
					start_cr   = 1'b1; // results of last set land this edge
					next_state = conflict_resolve_st;
				end
			end
			conflict_resolve_st: begin
				if (done_cr) begin
					start_write_mem = 1'b1;
					next_state      = write_st;
				end
			end
			write_st: begin
				if (done_write) begin
					frame_done = 1'b1;
					next_state = idle_st;
				end
			end
			default: next_state = idle_st;
		endcase
	end

endmodule

/* source/oflow_pe_array.sv */
// processing-element array
// two-entry set queue with credit return, then four lanes that scan
// the previous frame for the nearest centroid of each new box
`timescale 1ns/1ps

module oflow_pe_array (
	input  logic                                          clk,
	input  logic                                          reset_N,
	input  logic                                          set_valid,
	input  logic                                          start_pe,
	input  oflow_cfg_pkg::bbox_set_t                      set_bboxes,
	input  oflow_cfg_pkg::set_cnt_t                       set_index,
	input  oflow_cfg_pkg::bbox_cnt_t                      frame_bbox_cnt,
	input  oflow_cfg_pkg::bbox_cnt_t                      num_prev,
	input  oflow_cfg_pkg::bbox_t                          prev_bbox,
	output oflow_cfg_pkg::bbox_idx_t                      prev_addr,
	output logic                                          credit_return,
	output logic                                          res_we,
	output logic                                          done_set,
	output oflow_cfg_pkg::bbox_idx_t                      res_base,
	output oflow_cfg_pkg::bbox_set_t                      res_bboxes,
	output oflow_cfg_pkg::bbox_idx_t [oflow_cfg_pkg::PE_NUM-1:0] res_idx,
	output oflow_cfg_pkg::dist_t     [oflow_cfg_pkg::PE_NUM-1:0] res_dist
);
	import oflow_cfg_pkg::*;
	import oflow_ctrl_pkg::*;

	pe_state_t               state;
	bbox_set_t               q_mem [SET_CREDITS]; // set queue
	logic                    q_wr_ptr;
	logic                    q_rd_ptr;
	logic [1:0]              q_cnt;
	logic                    pop;
	bbox_set_t               cur_set;   // set under scan
	bbox_idx_t               prev_ptr;  // previous box stepped this cycle
	dist_t     [PE_NUM-1:0]  best_dist;
	bbox_idx_t [PE_NUM-1:0]  best_idx;
	dist_t     [PE_NUM-1:0]  lane_dist;
	logic      [PE_NUM-1:0]  lane_valid;

	function automatic dist_t abs_diff(coord_t a, coord_t b);
		return (a > b) ? dist_t'(a - b) : dist_t'(b - a);
	endfunction

	// --------------------------------------------------
	// queue, one credit back per pop
	assign pop           = (state == pe_wait_st) && start_pe && (q_cnt != 2'd0);
	assign credit_return = pop; // load cycle

	always_ff @(posedge clk) begin
		if (set_valid)
			q_mem[q_wr_ptr] <= set_bboxes;
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			q_wr_ptr <= 1'b0;
			q_rd_ptr <= 1'b0;
			q_cnt    <= 2'd0;
			state    <= pe_wait_st;
			prev_ptr <= '0;
		end else begin
			if (set_valid) q_wr_ptr <= ~q_wr_ptr;
			if (pop)       q_rd_ptr <= ~q_rd_ptr;
			q_cnt <= q_cnt + {1'b0, set_valid} - {1'b0, pop};
			case (state)
				pe_wait_st: begin
					prev_ptr <= '0;
					if (pop)
						state <= (num_prev == '0) ? pe_store_st : pe_scan_st; // no prev, skip
				end
				pe_scan_st: begin
					prev_ptr <= prev_ptr + 4'd1;
					if ({1'b0, prev_ptr} == num_prev - 5'd1)
						state <= pe_store_st;
				end
				default: state <= pe_wait_st; // store lasts one cycle
			endcase
		end
	end

	// --------------------------------------------------
	// lane compare, strict less keeps lowest index on ties
	always_comb begin
		for (int l = 0; l < PE_NUM; l++) begin
			lane_dist[l] = abs_diff(cur_set[l*16+8 +: 8], prev_bbox[15:8])
			             + abs_diff(cur_set[l*16 +: 8], prev_bbox[7:0]);
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			cur_set   <= q_mem[q_rd_ptr];
			best_dist <= '1; // max distance per lane
			best_idx  <= '0;
		end else if (state == pe_scan_st) begin
			for (int l = 0; l < PE_NUM; l++) begin
				if (lane_dist[l] < best_dist[l]) begin
					best_dist[l] <= lane_dist[l];
					best_idx[l]  <= prev_ptr;
				end
			end
		end
	end

	// --------------------------------------------------
	// store, lanes past the frame count carry zeros
	assign prev_addr = prev_ptr;
	assign res_we    = (state == pe_store_st);
	assign done_set  = res_we;
	assign res_base  = bbox_idx_t'({set_index, 2'b00}); // set index x 4

	always_comb begin
		for (int l = 0; l < PE_NUM; l++) begin
			lane_valid[l] = (bbox_cnt_t'(res_base) + bbox_cnt_t'(l)) < frame_bbox_cnt;
			res_bboxes[l*16 +: 16] = lane_valid[l] ? cur_set[l*16 +: 16] : '0;
			res_idx[l]  = lane_valid[l] ? best_idx[l] : '0;
			res_dist[l] = lane_valid[l] ? best_dist[l] : '0;
		end
	end

endmodule

/* source/oflow_mem_buffer.sv */
// frame memory buffer
// current frame boxes with search results and assigned ids,
// previous frame boxes with their track ids, one-cycle frame swap
`timescale 1ns/1ps

module oflow_mem_buffer (
	input  logic                                          clk,
	input  logic                                          reset_N,
	input  logic                                          res_we,
	input  oflow_cfg_pkg::bbox_idx_t                      res_base,
	input  oflow_cfg_pkg::bbox_set_t                      res_bboxes,
	input  oflow_cfg_pkg::bbox_idx_t [oflow_cfg_pkg::PE_NUM-1:0] res_idx,
	input  oflow_cfg_pkg::dist_t     [oflow_cfg_pkg::PE_NUM-1:0] res_dist,
	input  oflow_cfg_pkg::bbox_idx_t                      prev_addr,
	output oflow_cfg_pkg::bbox_t                          prev_bbox,
	input  oflow_cfg_pkg::bbox_idx_t                      cr_addr,
	output oflow_cfg_pkg::bbox_t                          cur_bbox,
	output oflow_cfg_pkg::bbox_idx_t                      cur_best_idx,
	output oflow_cfg_pkg::dist_t                          cur_best_dist,
	output oflow_cfg_pkg::track_id_t                      best_prev_id,
	input  logic                                          id_we,
	input  oflow_cfg_pkg::track_id_t                      id_in,
	input  logic                                          start_write_mem,
	input  oflow_cfg_pkg::bbox_cnt_t                      frame_bbox_cnt,
	output logic                                          done_write,
	output oflow_cfg_pkg::bbox_cnt_t                      num_prev
);
	import oflow_cfg_pkg::*;

	bbox_t     cur_bbox_mem  [MAX_BBOX]; // current frame
	bbox_idx_t cur_idx_mem   [MAX_BBOX];
	dist_t     cur_dist_mem  [MAX_BBOX];
	track_id_t cur_id_mem    [MAX_BBOX];
	bbox_t     prev_bbox_mem [MAX_BBOX]; // previous frame
	track_id_t prev_id_mem   [MAX_BBOX];

	// --------------------------------------------------
	// writes: pe results, resolver ids, swap
	always_ff @(posedge clk) begin
		if (res_we) begin
			for (int l = 0; l < PE_NUM; l++) begin
				cur_bbox_mem[res_base + bbox_idx_t'(l)] <= res_bboxes[l*16 +: 16];
				cur_idx_mem[res_base + bbox_idx_t'(l)]  <= res_idx[l];
				cur_dist_mem[res_base + bbox_idx_t'(l)] <= res_dist[l];
			end
		end
		if (id_we)
			cur_id_mem[cr_addr] <= id_in;
		if (start_write_mem) begin
			for (int i = 0; i < MAX_BBOX; i++) begin
				prev_bbox_mem[i] <= cur_bbox_mem[i];
				// last id of the frame is written in this same cycle
				prev_id_mem[i] <= (id_we && cr_addr == bbox_idx_t'(i)) ? id_in : cur_id_mem[i];
			end
		end
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			num_prev   <= '0;
			done_write <= 1'b0;
		end else begin
			done_write <= start_write_mem; // swap takes one cycle
			if (start_write_mem)
				num_prev <= frame_bbox_cnt;
		end
	end

	// combinational reads
	assign prev_bbox     = prev_bbox_mem[prev_addr];
	assign cur_bbox      = cur_bbox_mem[cr_addr];
	assign cur_best_idx  = cur_idx_mem[cr_addr];
	assign cur_best_dist = cur_dist_mem[cr_addr];
	assign best_prev_id  = prev_id_mem[cur_idx_mem[cr_addr]]; // id of nearest prev box

endmodule

/* source/oflow_conflict_resolve.sv */
// conflict resolver
// walks the frame's boxes in arrival order, accepts the nearest
// previous box when close enough and still unclaimed, else hands
// out a fresh track id, and emits each box with its id
`timescale 1ns/1ps

module oflow_conflict_resolve (
	input  logic                      clk,
	input  logic                      reset_N,
	input  logic                      start_cr,
	input  oflow_cfg_pkg::bbox_cnt_t  frame_bbox_cnt,
	output oflow_cfg_pkg::bbox_idx_t  cr_addr,
	input  oflow_cfg_pkg::bbox_t      cur_bbox,
	input  oflow_cfg_pkg::bbox_idx_t  cur_best_idx,
	input  oflow_cfg_pkg::dist_t      cur_best_dist,
	input  oflow_cfg_pkg::track_id_t  best_prev_id,
	output logic                      id_we,
	output oflow_cfg_pkg::track_id_t  id_in,
	output logic                      done_cr,
	output logic                      out_valid,
	output oflow_cfg_pkg::bbox_t      out_bbox,
	output oflow_cfg_pkg::track_id_t  out_id
);
	import oflow_cfg_pkg::*;

	logic                claimed_busy;
	logic [MAX_BBOX-1:0] claimed;  // prev boxes already taken this frame
	bbox_idx_t           idx;      // box being resolved
	track_id_t           next_id;  // fresh id counter, kept across frames
	logic                match;
	logic                last;

	// --------------------------------------------------
	// decision for the box at idx
	assign cr_addr = idx;
	assign match   = (cur_best_dist <= dist_t'(MATCH_DIST)) && !claimed[cur_best_idx];
	assign last    = claimed_busy && (bbox_cnt_t'(idx) + 5'd1 == frame_bbox_cnt);

	assign id_in     = match ? best_prev_id : next_id; // no prev boxes -> max dist -> fresh
	assign id_we     = claimed_busy;
	assign done_cr   = last;
	assign out_valid = claimed_busy;  // one box per cycle
	assign out_bbox  = cur_bbox;
	assign out_id    = id_in;

	// --------------------------------------------------
	// walk control
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			claimed_busy <= 1'b0;
			claimed      <= '0;
			idx          <= '0;
			next_id      <= '0;
		end else if (start_cr) begin
			claimed_busy <= 1'b1;
			claimed      <= '0; // new frame, nothing taken
			idx          <= '0;
		end else if (claimed_busy) begin
			idx <= idx + 4'd1;
			if (match)
				claimed[cur_best_idx] <= 1'b1;
			else
				next_id <= next_id + 8'd1; // wraps at 255
			if (last)
				claimed_busy <= 1'b0;
		end
	end

endmodule

/* source/oflow_core_top.sv */
// optical-flow tracker core
// sequencer, pe array, frame memory buffer and conflict resolver;
// credit-based set input, valid-only result stream
`timescale 1ns/1ps

module oflow_core_top (
	input  logic                     clk,
	input  logic                     reset_N,
	// frame control
	input  logic                     start,
	input  oflow_cfg_pkg::bbox_cnt_t num_of_bbox_in_frame,
	output logic                     ready_new_frame,
	output logic                     frame_done,
	// input sets
	input  logic                     set_valid,
	input  oflow_cfg_pkg::bbox_set_t set_bboxes,
	output logic                     credit_return,
	// results
	output logic                     out_valid,
	output oflow_cfg_pkg::bbox_t     out_bbox,
	output oflow_cfg_pkg::track_id_t out_id
);
	import oflow_cfg_pkg::*;

	// --------------------------------------------------
	// internal wires
	logic                   start_pe;
	logic                   start_cr;
	logic                   start_write_mem;
	logic                   done_set;
	logic                   done_cr;
	logic                   done_write;
	set_cnt_t               set_index;
	bbox_cnt_t              frame_bbox_cnt;
	frame_num_t             frame_num;  // observed by checkers only
	bbox_cnt_t              num_prev;
	bbox_idx_t              prev_addr;
	bbox_t                  prev_bbox;
	logic                   res_we;
	bbox_idx_t              res_base;
	bbox_set_t              res_bboxes;
	bbox_idx_t [PE_NUM-1:0] res_idx;
	dist_t     [PE_NUM-1:0] res_dist;
	bbox_idx_t              cr_addr;
	bbox_t                  cur_bbox;
	bbox_idx_t              cur_best_idx;
	dist_t                  cur_best_dist;
	track_id_t              best_prev_id;
	logic                   id_we;
	track_id_t              id_in;

	oflow_core_fsm u_core_fsm (
		.clk, .reset_N, .start, .num_of_bbox_in_frame,
		.done_set, .done_cr, .done_write,
		.ready_new_frame, .start_pe, .start_cr, .start_write_mem, .frame_done,
		.set_index, .frame_bbox_cnt, .frame_num
	);

	oflow_pe_array u_pe_array (
		.clk, .reset_N, .set_valid, .start_pe, .set_bboxes,
		.set_index, .frame_bbox_cnt, .num_prev, .prev_bbox, .prev_addr,
		.credit_return, .res_we, .done_set,
		.res_base, .res_bboxes, .res_idx, .res_dist
	);

	oflow_mem_buffer u_mem_buffer (
		.clk, .reset_N, .res_we, .res_base, .res_bboxes, .res_idx, .res_dist,
		.prev_addr, .prev_bbox,
		.cr_addr, .cur_bbox, .cur_best_idx, .cur_best_dist, .best_prev_id,
		.id_we, .id_in,
		.start_write_mem, .frame_bbox_cnt, .done_write, .num_prev
	);

	oflow_conflict_resolve u_conflict_resolve (
		.clk, .reset_N, .start_cr, .frame_bbox_cnt,
		.cr_addr, .cur_bbox, .cur_best_idx, .cur_best_dist, .best_prev_id,
		.id_we, .id_in, .done_cr,
		.out_valid, .out_bbox, .out_id
	);

endmodule

/* verification/oflow_clk_gen.sv */
// testbench clock and reset
// 100 ns clock, active-low reset held for four cycles
`timescale 1ns/1ps

module oflow_clk_gen (
	output logic clk,
	output logic reset_N
);
	localparam time HALF_PERIOD = 50ns;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		reset_N = 1'b0;
		repeat (4) @(posedge clk);
		#10ns reset_N = 1'b1; // released off the edge
	end

endmodule

/* verification/oflow_core_chk.sv */
// tracker core checker
// bound into the core top, watches credits, phase pulses
// and the order of the result stream
`timescale 1ns/1ps

module oflow_core_chk (
	input logic                        clk,
	input logic                        reset_N,
	input logic                        set_valid,
	input logic                        credit_return,
	input logic                        done_cr,
	input logic                        out_valid,
	input logic                        frame_done,
	input oflow_ctrl_pkg::core_state_t core_state
);
	import oflow_ctrl_pkg::*;

	int         fail_cnt = 0; // failed assertions so far
	logic [2:0] sets_held;    // sets queued, credit not back yet

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			sets_held <= '0;
		else
			sets_held <= sets_held + {2'b00, set_valid} - {2'b00, credit_return};
	end

	// --------------------------------------------------
	// credits and sets
	a_credits_home: assert property (@(posedge clk) disable iff (!reset_N)
		frame_done |-> sets_held == 3'd0)
		else begin
			$error("frame ended with a set still waiting for its credit");
			fail_cnt++;
		end

	a_set_in_frame: assert property (@(posedge clk) disable iff (!reset_N)
		set_valid |-> core_state inside {set_variables_st, scan_st})
		else begin
			$error("set arrived with no frame accepted");
			fail_cnt++;
		end

	// --------------------------------------------------
	// result stream, one unbroken run per frame
	a_out_in_resolve: assert property (@(posedge clk) disable iff (!reset_N)
		out_valid |-> core_state == conflict_resolve_st)
		else begin
			$error("result emitted outside conflict resolve");
			fail_cnt++;
		end

	a_stream_unbroken: assert property (@(posedge clk) disable iff (!reset_N)
		core_state == conflict_resolve_st |-> out_valid)
		else begin
			$error("gap in result stream");
			fail_cnt++;
		end

	// swap takes one cycle after the last result
	a_write_after_resolve: assert property (@(posedge clk) disable iff (!reset_N)
		done_cr |=> frame_done)
		else begin
			$error("frame_done not the cycle after done_cr");
			fail_cnt++;
		end

endmodule

bind oflow_core_top oflow_core_chk u_core_chk (
	.clk,
	.reset_N,
	.set_valid,
	.credit_return,
	.done_cr,
	.out_valid,
	.frame_done,
	.core_state (u_core_fsm.state)
);

/* verification/oflow_core_tb.sv */
// tracker core testbench
// directed frames plus seeded random frames, credit-based sender,
// matching model for expected ids, watchdog and summary
`timescale 1ns/1ps

module oflow_core_tb;
	import oflow_cfg_pkg::*;

	localparam time DRIVE_DLY    = 10ns;
	localparam int  RAND_FRAMES  = 6;
	localparam int  NUM_FRAMES   = 4 + RAND_FRAMES; // directed + random
	localparam int  FRAME_CYCLES = 200;             // per-frame bound
	localparam int  WATCHDOG_NS  = (NUM_FRAMES * FRAME_CYCLES + 50) * 100;

	logic      clk;
	logic      reset_N;
	logic      start;
	bbox_cnt_t num_of_bbox_in_frame;
	logic      ready_new_frame;
	logic      frame_done;
	logic      set_valid;
	bbox_set_t set_bboxes;
	logic      credit_return;
	logic      out_valid;
	bbox_t     out_bbox;
	track_id_t out_id;

	int        credits;            // sender side credits
	int        sets_sent;
	int        first_credit_sets;  // sets out when first credit came back
	logic      seen_credit;
	int        frames_run;         // frames completed so far
	int        errors;
	int        tests_run;
	int        tests_failed;
	integer    seed = 15;
	bbox_t     frame_boxes [MAX_BBOX];
	track_id_t exp_id [MAX_BBOX];
	bbox_t     got_box [$];
	track_id_t got_id [$];
	// matching model state
	bbox_t     model_prev_box [MAX_BBOX];
	track_id_t model_prev_id [MAX_BBOX];
	int        model_num_prev;
	track_id_t model_next_id;

	oflow_clk_gen u_clk_gen (.clk, .reset_N);

	oflow_core_top u_dut (
		.clk, .reset_N,
		.start, .num_of_bbox_in_frame, .ready_new_frame, .frame_done,
		.set_valid, .set_bboxes, .credit_return,
		.out_valid, .out_bbox, .out_id
	);

	// --------------------------------------------------
	// watchdog
	initial begin
		#(WATCHDOG_NS * 1ns);
		$display("watchdog expired at %0t, a frame never completed", $time);
		$display("TESTS FAILED");
		$finish;
	end

	// --------------------------------------------------
	// monitors, sampled mid-cycle
	always @(negedge clk) begin
		if (reset_N && out_valid) begin
			got_box.push_back(out_bbox);
			got_id.push_back(out_id);
		end
		if (reset_N && credit_return) begin
			if (!seen_credit)
				first_credit_sets = sets_sent;
			seen_credit = 1'b1;
			credits     = credits + 1;
			assert (credits <= SET_CREDITS) else begin
				$display("credit returned at %0t with no set outstanding", $time);
				errors++;
			end
		end
	end

	// --------------------------------------------------
	// matching model
	function automatic int manhattan(bbox_t a, bbox_t b);
		int dx;
		int dy;
		dx = int'(a[15:8]) - int'(b[15:8]);
		dy = int'(a[7:0]) - int'(b[7:0]);
		return ((dx < 0) ? -dx : dx) + ((dy < 0) ? -dy : dy);
	endfunction

	task automatic model_frame(input int n);
		int                  best_j;
		int                  best_d;
		int                  d;
		logic [MAX_BBOX-1:0] taken;
		taken = '0;
		for (int i = 0; i < n; i++) begin
			best_d = -1; // none yet
			best_j = 0;
			for (int j = 0; j < model_num_prev; j++) begin
				d = manhattan(frame_boxes[i], model_prev_box[j]);
				if (best_d < 0 || d < best_d) begin // first wins ties
					best_d = d;
					best_j = j;
				end
			end
			if (best_d >= 0 && best_d <= MATCH_DIST && !taken[best_j]) begin
				exp_id[i]     = model_prev_id[best_j];
				taken[best_j] = 1'b1;
			end else begin
				exp_id[i]     = model_next_id;
				model_next_id = model_next_id + 8'd1;
			end
		end
		for (int i = 0; i < n; i++) begin
			model_prev_box[i] = frame_boxes[i];
			model_prev_id[i]  = exp_id[i];
		end
		model_num_prev = n;
	endtask

	// --------------------------------------------------
	// sender and frame driver
	task automatic send_set(input bbox_set_t s);
		while (credits == 0) begin // stall, no credit held
			@(posedge clk);
			#DRIVE_DLY;
		end
		set_valid  = 1'b1;
		set_bboxes = s;
		credits    = credits - 1;
		sets_sent  = sets_sent + 1;
		@(posedge clk);
		#DRIVE_DLY;
		set_valid = 1'b0;
	endtask

	task automatic check_stream(input int n);
		assert (got_box.size() == n) else begin
			$display("Mismatch at %0t: %0d results emitted, expected %0d",
				$time, got_box.size(), n);
			errors++;
		end
		for (int i = 0; i < n && i < got_box.size(); i++) begin
			assert (got_box[i] == frame_boxes[i] && got_id[i] == exp_id[i]) else begin
				$display("Mismatch at %0t: result %0d box %h id %0d, expected box %h id %0d",
					$time, i, got_box[i], got_id[i], frame_boxes[i], exp_id[i]);
				errors++;
			end
		end
	endtask

	task automatic run_frame(input int n, input int max_pause);
		int        nsets;
		int        pause;
		int        k;
		bbox_set_t s;
		nsets = (n + PE_NUM - 1) / PE_NUM;
		model_frame(n);
		@(negedge clk);
		while (!ready_new_frame)
			@(negedge clk);
		got_box.delete();
		got_id.delete();
		@(posedge clk);
		#DRIVE_DLY;
		start                = 1'b1;
		num_of_bbox_in_frame = bbox_cnt_t'(n);
		@(posedge clk);
		#DRIVE_DLY;
		start = 1'b0;
		for (int si = 0; si < nsets; si++) begin
			for (int lane = 0; lane < PE_NUM; lane++) begin
				k = si * PE_NUM + lane;
				s[lane*16 +: 16] = (k < n) ? frame_boxes[k] : 16'hdead; // junk lanes
			end
			send_set(s);
			if (si < nsets - 1 && max_pause > 0) begin
				pause = $unsigned($random(seed)) % (max_pause + 1);
				repeat (pause) begin
					@(posedge clk);
					#DRIVE_DLY;
				end
			end
		end
		@(negedge clk);
		while (!frame_done)
			@(negedge clk);
		@(negedge clk);
		assert (ready_new_frame) else begin
			$display("Mismatch at %0t: ready_new_frame low the cycle after frame_done", $time);
			errors++;
		end
		assert (credits == SET_CREDITS) else begin
			$display("credits not all returned after the frame, %0d held", credits);
			errors++;
		end
		frames_run++;
		assert (u_dut.frame_num == frame_num_t'(frames_run)) else begin
			$display("Mismatch at %0t: frame_num %0d after %0d frames", $time,
				u_dut.frame_num, frames_run);
			errors++;
		end
		check_stream(n);
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	// --------------------------------------------------
	// directed tests
	task automatic test_reset_state();
		int e;
		e = errors;
		@(negedge clk);
		assert (ready_new_frame === 1'b1) else begin
			$display("Mismatch at %0t: ready_new_frame %b after reset", $time, ready_new_frame);
			errors++;
		end
		assert (out_valid === 1'b0 && credit_return === 1'b0 && frame_done === 1'b0) else begin
			$display("Mismatch at %0t: output pulses active after reset", $time);
			errors++;
		end
		assert (credits == SET_CREDITS) else begin
			$display("Mismatch at %0t: sender holds %0d credits", $time, credits);
			errors++;
		end
		report_test("reset_state", e);
	endtask

	task automatic test_first_frame();
		int e;
		e = errors;
		frame_boxes[0] = 16'h0a0a;
		frame_boxes[1] = 16'h320a;
		frame_boxes[2] = 16'h5a0a;
		frame_boxes[3] = 16'h0a3c;
		frame_boxes[4] = 16'h323c;
		frame_boxes[5] = 16'h5a3c;
		run_frame(6, 0); // two sets, last one partial
		assert (first_credit_sets == SET_CREDITS) else begin
			$display("Mismatch at %0t: %0d sets sent before first credit", $time,
				first_credit_sets);
			errors++;
		end
		for (int i = 0; i < 6 && i < got_id.size(); i++) begin
			assert (got_id[i] == track_id_t'(i)) else begin
				$display("Mismatch at %0t: first frame box %0d id %0d", $time, i, got_id[i]);
				errors++;
			end
		end
		report_test("first_frame", e);
	endtask

	task automatic test_shifted_frame();
		int e;
		e = errors;
		frame_boxes[0] = 16'h0c0b; // small shifts keep ids
		frame_boxes[1] = 16'h300d;
		frame_boxes[2] = 16'h96c8; // moved far, fresh id
		frame_boxes[3] = 16'h0d39;
		frame_boxes[4] = 16'h353e;
		frame_boxes[5] = 16'h583a;
		run_frame(6, 0);
		report_test("shifted_frame", e);
	endtask

	task automatic test_conflict();
		int e;
		e = errors;
		frame_boxes[0] = 16'h6464; // lone previous box
		run_frame(1, 0);
		frame_boxes[0] = 16'h6664; // both nearest to it
		frame_boxes[1] = 16'h6467;
		run_frame(2, 0);
		report_test("conflict", e);
	endtask

	task automatic test_random_frames();
		int          e;
		int          n;
		logic [31:0] r;
		e = errors;
		for (int f = 0; f < RAND_FRAMES; f++) begin
			n = $unsigned($random(seed)) % MAX_BBOX + 1;
			for (int i = 0; i < n; i++) begin
				r = $random(seed);
				if (i < model_num_prev && r[0]) // jitter an old box
					frame_boxes[i] = {model_prev_box[i][15:8] + coord_t'(r[3:1]),
						model_prev_box[i][7:0] - coord_t'(r[6:4])};
				else
					frame_boxes[i] = r[23:8];
			end
			run_frame(n, 3);
		end
		report_test("random_frames", e);
	endtask

	// --------------------------------------------------
	// main sequence
	initial begin
		start                = 1'b0;
		num_of_bbox_in_frame = '0;
		set_valid            = 1'b0;
		set_bboxes           = '0;
		credits              = SET_CREDITS;
		sets_sent            = 0;
		first_credit_sets    = 0;
		seen_credit          = 1'b0;
		frames_run           = 0;
		errors               = 0;
		tests_run            = 0;
		tests_failed         = 0;
		model_num_prev       = 0;
		model_next_id        = '0;
		@(posedge reset_N);
		repeat (2) @(posedge clk);
		#DRIVE_DLY;
		test_reset_state();
		test_first_frame();
		test_shifted_frame();
		test_conflict();
		test_random_frames();
		if (u_dut.u_core_chk.fail_cnt != 0) begin
			$display("bound assertions failed %0d times", u_dut.u_core_chk.fail_cnt);
			errors = errors + u_dut.u_core_chk.fail_cnt;
		end
		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* oflow.f */
source/oflow_cfg_pkg.sv
source/oflow_ctrl_pkg.sv
source/oflow_core_fsm.sv
source/oflow_pe_array.sv
source/oflow_mem_buffer.sv
source/oflow_conflict_resolve.sv
source/oflow_core_top.sv
verification/oflow_clk_gen.sv
verification/oflow_core_chk.sv
verification/oflow_core_tb.sv

/* Bender.yml */
package:
  name: oflow

sources:
  # packages first, then the design
  - source/oflow_cfg_pkg.sv
  - source/oflow_ctrl_pkg.sv
  - source/oflow_core_fsm.sv
  - source/oflow_pe_array.sv
  - source/oflow_mem_buffer.sv
  - source/oflow_conflict_resolve.sv
  - source/oflow_core_top.sv
  - target: test
    files:
      - verification/oflow_clk_gen.sv
      - verification/oflow_core_chk.sv
      - verification/oflow_core_tb.sv
